/* hdl/video_consts.svh */
// ------------------------------------------------
// video bridge constants
// VGA 640x480 timing, Atari line size, column
// scaling, TIA hold threshold and output latency
// ------------------------------------------------
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal timing in clocks
`define H_VISIBLE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

// vertical timing in lines
`define V_VISIBLE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// atari line and scaling
`define TIA_LINE_PIXELS 160
`define X_SCALE_SHIFT 2
`define HOLD_FIRST_LINE 36
`define PIPE_DEPTH 2

`endif

/* hdl/video_pkg.sv */
// ------------------------------------------------
// video bridge types
// TIA pixel stream, VGA scan position, palette
// colour and the packed 2-2-2 VGA output word
// ------------------------------------------------
package video_pkg;

  // tia colour, hue in the top nibble
  typedef struct packed {
    logic [3:0] hue;
    logic [2:0] luma;
  } tia_color_t;

  // one pixel of the TIA output stream
  typedef struct packed {
    logic [7:0] xpos;
    logic [8:0] ypos;
    tia_color_t color;
    logic       vsync;
    logic       vblank;
  } tia_pixel_t;

  // vga beam position, sync levels active low
  typedef struct packed {
    logic [9:0] hpos;
    logic [9:0] vpos;
    logic       hsync;
    logic       vsync;
    logic       display_on;
  } scan_pos_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb24_t;

  // pins of the vga connector
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic [1:0] r;
    logic [1:0] g;
    logic [1:0] b;
  } vga_out_t;

endpackage

/* hdl/vga_timing.sv */
// ------------------------------------------------
// vga 640x480 timing generator
// free-running beam counters, sync levels and
// the display-on window, one step per clock
// ------------------------------------------------
`timescale 1ns/1ns
`include "video_consts.svh"

module vga_timing
  import video_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  output scan_pos_t scan
);

  // sync pulse windows, end is exclusive
  localparam int HS_START = `H_VISIBLE + `H_FRONT;
  localparam int HS_END   = HS_START + `H_SYNC;
  localparam int VS_START = `V_VISIBLE + `V_FRONT;
  localparam int VS_END   = VS_START + `V_SYNC;

  logic [9:0] hpos;
  logic [9:0] vpos;

  // ------------------------------------------------
  // beam counters
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hpos <= 10'd0;
      vpos <= 10'd0;
    end else if (hpos == `H_TOTAL - 1) begin
      hpos <= 10'd0;
      // wrap the frame after the back porch lines
      if (vpos == `V_TOTAL - 1) begin
        vpos <= 10'd0;
      end else begin
        vpos <= vpos + 10'd1;
      end
    end else begin
      hpos <= hpos + 10'd1;
    end
  end

  // ------------------------------------------------
  // decoded levels
  // ------------------------------------------------
  assign scan.hpos = hpos;
  assign scan.vpos = vpos;

  // both syncs low inside their pulse window
  assign scan.hsync = !((hpos >= HS_START) && (hpos < HS_END));
  assign scan.vsync = !((vpos >= VS_START) && (vpos < VS_END));

  assign scan.display_on = (hpos < `H_VISIBLE) && (vpos < `V_VISIBLE);

endmodule

/* hdl/line_writer.sv */
// ------------------------------------------------
// tia line writer
// stores visible TIA pixels into the line buffer
// and asks the system to wait for the VGA beam
// ------------------------------------------------
`timescale 1ns/1ns
`include "video_consts.svh"

module line_writer
  import video_pkg::*;
(
  input  tia_pixel_t tia,
  input  scan_pos_t  scan,
  output logic       wr_en,
  output logic [7:0] wr_addr,
  output tia_color_t wr_data,
  output logic       tia_hold
);

  // vga line reached by the current atari line
  logic [9:0] vga_line_needed;

  // ------------------------------------------------
  // buffer write
  // ------------------------------------------------
  // horizontal blank positions are past the line end
  assign wr_en   = (tia.xpos < `TIA_LINE_PIXELS);
  assign wr_addr = tia.xpos;
  assign wr_data = tia.color;

  // ------------------------------------------------
  // hold
  // ------------------------------------------------
  // every atari line fills two vga lines
  assign vga_line_needed = {tia.ypos, 1'b0};

  // lines above the threshold are top border, run free
  assign tia_hold = (tia.ypos > `HOLD_FIRST_LINE) &&
                    (scan.vpos < vga_line_needed);

endmodule

/* hdl/scanline_buffer.sv */
// ------------------------------------------------
// single line buffer
// one write port, one read port with a registered
// output, payload type chosen by the parent
// ------------------------------------------------
`timescale 1ns/1ns

module scanline_buffer
  import video_pkg::*;
#(
  parameter type payload_t = tia_color_t,
  parameter int  DEPTH     = 256
) (
  input  logic                     clk,
  input  logic                     wr_en,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  payload_t                 wr_data,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output payload_t                 rd_data
);

  payload_t mem [DEPTH];

  // write lands at the end of the enable cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // read data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

/* hdl/ntsc_palette.sv */
// ------------------------------------------------
// ntsc colour palette
// maps TIA hue and luma to 24-bit rgb, hue 0 is
// the grey ramp, others scale a base colour
// ------------------------------------------------
`timescale 1ns/1ns

module ntsc_palette
  import video_pkg::*;
(
  input  tia_color_t color,
  output rgb24_t     rgb
);

  rgb24_t      base;
  logic [7:0]  grey;
  logic [10:0] r_scaled;
  logic [10:0] g_scaled;
  logic [10:0] b_scaled;

  // brightest shade of each hue
  always_comb begin
    case (color.hue)
      4'd1:    base = 24'hfcfc68;
      4'd2:    base = 24'hfcbc74;
      4'd3:    base = 24'hfcb490;
      4'd4:    base = 24'hfcb0c0;
      4'd5:    base = 24'hfcb0f4;
      4'd6:    base = 24'hd4b0fc;
      4'd7:    base = 24'hb8b4fc;
      4'd8:    base = 24'ha4c8fc;
      4'd9:    base = 24'ha4e0fc;
      4'd10:   base = 24'ha4fcd4;
      4'd11:   base = 24'hb8fcb8;
      4'd12:   base = 24'hc8fcac;
      4'd13:   base = 24'he0fc9c;
      4'd14:   base = 24'hfce08c;
      4'd15:   base = 24'hfcd09c;
      // hue 0 takes the grey path below
      default: base = 24'hffffff;
    endcase
  end

  // grey ramp, 0 to 252 in steps of 36
  assign grey = {5'd0, color.luma} * 8'd36;

  // base times (luma + 1) / 8
  assign r_scaled = base.r * (color.luma + 4'd1);
  assign g_scaled = base.g * (color.luma + 4'd1);
  assign b_scaled = base.b * (color.luma + 4'd1);

  assign rgb.r = (color.hue == 4'd0) ? grey : r_scaled[10:3];
  assign rgb.g = (color.hue == 4'd0) ? grey : g_scaled[10:3];
  assign rgb.b = (color.hue == 4'd0) ? grey : b_scaled[10:3];

endmodule

/* hdl/vga_scan_out.sv */
// ------------------------------------------------
// vga scan out
// reads the stored line at 4x width, runs it
// through the palette and registers a 2-2-2
// output with matching sync and blanking
// ------------------------------------------------
`timescale 1ns/1ns
`include "video_consts.svh"

module vga_scan_out
  import video_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  scan_pos_t  scan,
  input  logic       vblank,
  output logic [7:0] rd_addr,
  input  tia_color_t rd_data,
  output vga_out_t   vga
);

  // control stages ahead of the output register
  localparam int CTL_STAGES = `PIPE_DEPTH - 1;

  logic [CTL_STAGES-1:0] hsync_d;
  logic [CTL_STAGES-1:0] vsync_d;
  logic [CTL_STAGES-1:0] blank_d;
  rgb24_t                rgb;

  // four vga columns per atari pixel
  assign rd_addr = scan.hpos[`X_SCALE_SHIFT +: 8];

  // ------------------------------------------------
  // control delay to line up with the buffer read
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hsync_d <= '1;
      vsync_d <= '1;
      blank_d <= '1;
    end else begin
      hsync_d[0] <= scan.hsync;
      vsync_d[0] <= scan.vsync;
      // black outside the visible area and in tia vblank
      blank_d[0] <= !scan.display_on || vblank;
    end
  end

  ntsc_palette palette0 (
    .color (rd_data),
    .rgb   (rgb)
  );

  // ------------------------------------------------
  // output register
  // ------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.r     <= 2'b00;
      vga.g     <= 2'b00;
      vga.b     <= 2'b00;
    end else begin
      vga.hsync <= hsync_d[CTL_STAGES-1];
      vga.vsync <= vsync_d[CTL_STAGES-1];
      if (blank_d[CTL_STAGES-1]) begin
        vga.r <= 2'b00;
        vga.g <= 2'b00;
        vga.b <= 2'b00;
      end else begin
        // plain truncation to the top two bits
        vga.r <= rgb.r[7:6];
        vga.g <= rgb.g[7:6];
        vga.b <= rgb.b[7:6];
      end
    end
  end

endmodule

/* hdl/audio_pwm.sv */
// ------------------------------------------------
// tia audio pwm
// first-order accumulator, the carry out is the
// pwm bit, density follows the 5-bit level
// ------------------------------------------------
`timescale 1ns/1ns

module audio_pwm (
  input  logic       clk,
  input  logic       rst_n,
  input  logic [4:0] level,
  output logic       pwm
);

  // bit 5 holds the carry of the last add
  logic [5:0] acc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= 6'd0;
    end else begin
      acc <= {1'b0, acc[4:0]} + {1'b0, level};
    end
  end

  assign pwm = acc[5];

endmodule

/* hdl/tia_vga_bridge.sv */
// ------------------------------------------------
// tia to vga bridge, top level
// line writer into the line buffer, vga scan out
// from it, beam timing and audio pwm
// ------------------------------------------------
`timescale 1ns/1ns

module tia_vga_bridge
  import video_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  tia_pixel_t tia,
  input  logic [4:0] tia_audio,
  output logic       tia_hold,
  output vga_out_t   vga,
  output logic       audio_out
);

  scan_pos_t  scan;
  logic       wr_en;
  logic [7:0] wr_addr;
  tia_color_t wr_data;
  logic [7:0] rd_addr;
  tia_color_t rd_data;

  vga_timing timing0 (
    .clk   (clk),
    .rst_n (rst_n),
    .scan  (scan)
  );

  // ------------------------------------------------
  // tia side
  // ------------------------------------------------
  line_writer writer0 (
    .tia      (tia),
    .scan     (scan),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .tia_hold (tia_hold)
  );

  scanline_buffer #(
    .payload_t (tia_color_t),
    .DEPTH     (256)
  ) line_buf0 (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  // ------------------------------------------------
  // vga side
  // ------------------------------------------------
  vga_scan_out scan_out0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .scan    (scan),
    .vblank  (tia.vblank),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .vga     (vga)
  );

  audio_pwm audio0 (
    .clk   (clk),
    .rst_n (rst_n),
    .level (tia_audio),
    .pwm   (audio_out)
  );

endmodule

/* verif/tia_vga_bridge_tb.sv */
// ------------------------------------------------
// testbench for the tia to vga bridge
// directed tests of sync timing, line buffer,
// palette, blanking, tia hold and audio pwm
// ------------------------------------------------
`timescale 1ns/1ns
`include "video_consts.svh"

module tia_vga_bridge_tb
  import video_pkg::*;
();

  logic       clk;
  logic       rst_n;
  tia_pixel_t tia;
  logic [4:0] tia_audio;
  logic       tia_hold;
  vga_out_t   vga;
  logic       audio_out;

  int          errors;
  int          checks;
  bit          aborted;
  logic [31:0] lcg_state;
  // lumas of the line last written
  logic [2:0]  lumas [`TIA_LINE_PIXELS];

  tia_vga_bridge dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .tia       (tia),
    .tia_audio (tia_audio),
    .tia_hold  (tia_hold),
    .vga       (vga),
    .audio_out (audio_out)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ------------------------------------------------
  // helpers
  // ------------------------------------------------
  function automatic logic [2:0] next_random_luma();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[30:28];
  endfunction

  function automatic logic sync_level(input bit vertical);
    return vertical ? vga.vsync : vga.hsync;
  endfunction

  // sampled on falling edges, cycles counts them up to the edge
  task automatic wait_sync_edge(input bit vertical, input logic to_level,
                                input int limit, output int cycles);
    logic prev;
    logic cur;
    bit   seen;
    prev   = sync_level(vertical);
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      @(negedge clk);
      cur  = sync_level(vertical);
      seen = (prev != to_level) && (cur == to_level);
      prev = cur;
      cycles++;
    end
    checks++;
    assert (seen) else begin
      $display("timeout: no %s %s edge within %0d cycles",
               to_level ? "rising" : "falling", vertical ? "vsync" : "hsync", limit);
      errors++;
      aborted = 1'b1;
    end
  endtask

  task automatic check_rgb(input logic [1:0] r, input logic [1:0] g,
                           input logic [1:0] b, input int col);
    checks++;
    assert (vga.r == r) else begin
      $display("ERR vga.r col %0d: expected %h, got %h", col, r, vga.r);
      errors++;
    end
    assert (vga.g == g) else begin
      $display("ERR vga.g col %0d: expected %h, got %h", col, g, vga.g);
      errors++;
    end
    assert (vga.b == b) else begin
      $display("ERR vga.b col %0d: expected %h, got %h", col, b, vga.b);
      errors++;
    end
  endtask

  task automatic test_done(input string name, input int start_errors);
    $display("test %s: %0d errors", name, errors - start_errors);
  endtask

  // one full atari line of grey pixels, then park xpos off the line
  task automatic write_grey_line();
    for (int i = 0; i < `TIA_LINE_PIXELS; i++) begin
      @(posedge clk);
      #2;
      lumas[i]       = next_random_luma();
      tia.xpos       = i[7:0];
      tia.color.hue  = 4'd0;
      tia.color.luma = lumas[i];
    end
    @(posedge clk);
    #2;
    tia.xpos = 8'd200;
  endtask

  // ------------------------------------------------
  // directed tests
  // ------------------------------------------------
  task automatic test_reset_state();
    int e0;
    e0 = errors;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      checks++;
      assert (vga.hsync && vga.vsync) else begin
        $display("ERR vga.hsync/vga.vsync: expected 1/1, got %h/%h", vga.hsync, vga.vsync);
        errors++;
      end
      assert (!tia_hold) else begin
        $display("ERR tia_hold: expected 0, got %h", tia_hold);
        errors++;
      end
      assert (!audio_out) else begin
        $display("ERR audio_out cycle %0d: expected 0, got %h", i, audio_out);
        errors++;
      end
    end
    test_done("reset_state", e0);
  endtask

  task automatic test_sync(input bit vertical, input int low_exp, input int period_exp,
                           input string name);
    int c_low;
    int c_high;
    int e0;
    e0 = errors;
    // align to a falling edge, then measure one period
    wait_sync_edge(vertical, 1'b0, period_exp + 10, c_low);
    wait_sync_edge(vertical, 1'b1, period_exp + 10, c_low);
    wait_sync_edge(vertical, 1'b0, period_exp + 10, c_high);
    if (!aborted) begin
      checks++;
      assert (c_low == low_exp) else begin
        $display("ERR %s low cycles: expected %h, got %h", name, low_exp, c_low);
        errors++;
      end
      assert (c_low + c_high == period_exp) else begin
        $display("ERR %s period: expected %h, got %h", name, period_exp, c_low + c_high);
        errors++;
      end
    end
    test_done(name, e0);
  endtask

  task automatic test_line_buffer();
    int         c;
    int         e0;
    logic [7:0] grey;
    e0 = errors;
    // vsync ends on line 492, 32 hsync ends later the output is on line 523
    wait_sync_edge(1'b1, 1'b1, `V_TOTAL * `H_TOTAL + 10, c);
    for (int i = 0; i < 32 && !aborted; i++) begin
      wait_sync_edge(1'b0, 1'b1, `H_TOTAL + 10, c);
    end
    write_grey_line();
    // end of hsync on line 524, back porch brings line 0 column 0
    wait_sync_edge(1'b0, 1'b1, `H_TOTAL + 10, c);
    repeat (`H_BACK) @(negedge clk);
    for (int col = 0; col < `H_VISIBLE && !aborted; col++) begin
      if (col > 0) @(negedge clk);
      grey = lumas[col >> `X_SCALE_SHIFT] * 8'd36;
      check_rgb(grey[7:6], grey[7:6], grey[7:6], col);
    end
    // a coloured pixel at the line start
    @(posedge clk);
    #2;
    tia.xpos       = 8'd0;
    tia.color.hue  = 4'd5;
    tia.color.luma = 3'd7;
    @(posedge clk);
    #2;
    tia.xpos = 8'd200;
    wait_sync_edge(1'b0, 1'b1, `H_TOTAL + 10, c);
    repeat (`H_BACK) @(negedge clk);
    checks++;
    assert ((vga.r | vga.g | vga.b) != 2'b00) else begin
      $display("ERR vga rgb for hue 5 luma 7: expected non-zero, got %h %h %h",
               vga.r, vga.g, vga.b);
      errors++;
    end
    test_done("line_buffer", e0);
  endtask

  task automatic test_blanking();
    int c;
    int e0;
    e0 = errors;
    @(posedge clk);
    #2;
    tia.vblank = 1'b1;
    wait_sync_edge(1'b0, 1'b1, `H_TOTAL + 10, c);
    repeat (`H_BACK) @(negedge clk);
    for (int col = 0; col < `H_VISIBLE && !aborted; col++) begin
      if (col > 0) @(negedge clk);
      check_rgb(2'b00, 2'b00, 2'b00, col);
    end
    @(posedge clk);
    #2;
    tia.vblank = 1'b0;
    // horizontal blank while hsync is low
    wait_sync_edge(1'b0, 1'b0, `H_TOTAL + 10, c);
    for (int i = 0; i < `H_SYNC && !aborted; i++) begin
      if (i > 0) @(negedge clk);
      assert (!vga.hsync) else begin
        $display("ERR vga.hsync in pulse cycle %0d: expected 0, got %h", i, vga.hsync);
        errors++;
      end
      check_rgb(2'b00, 2'b00, 2'b00, `H_VISIBLE + `H_FRONT + i);
    end
    test_done("blanking", e0);
  endtask

  // any 32-cycle window after settling holds exactly level ones
  task automatic check_audio(input logic [4:0] level);
    int ones;
    bit samples [64];
    @(posedge clk);
    #2;
    tia_audio = level;
    repeat (32) @(negedge clk);
    for (int i = 0; i < 64; i++) begin
      @(negedge clk);
      samples[i] = audio_out;
    end
    for (int s = 0; s <= 32; s++) begin
      ones = 0;
      for (int k = 0; k < 32; k++) begin
        ones += samples[s + k];
      end
      checks++;
      assert (ones == level) else begin
        $display("ERR audio_out ones at level %h window %0d: expected %h, got %h",
                 level, s, level, ones);
        errors++;
      end
    end
  endtask

  task automatic test_hold_audio();
    int e0;
    e0 = errors;
    // beam is near the frame top here, vpos well below 200
    @(posedge clk);
    #2;
    tia.ypos = 9'd100;
    @(negedge clk);
    checks++;
    assert (tia_hold) else begin
      $display("ERR tia_hold at ypos 100: expected 1, got %h", tia_hold);
      errors++;
    end
    @(posedge clk);
    #2;
    tia.ypos = 9'd20;
    @(negedge clk);
    checks++;
    assert (!tia_hold) else begin
      $display("ERR tia_hold at ypos 20: expected 0, got %h", tia_hold);
      errors++;
    end
    check_audio(5'd0);
    check_audio(5'd9);
    check_audio(5'd31);
    test_done("hold_audio", e0);
  endtask

  // ------------------------------------------------
  // main sequence
  // ------------------------------------------------
  initial begin
    lcg_state = 32'h63c6a110;
    errors    = 0;
    checks    = 0;
    aborted   = 1'b0;
    rst_n     = 1'b0;
    tia       = '0;
    tia.xpos  = 8'd200;
    tia_audio = 5'd0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_state();
    if (!aborted) test_sync(1'b0, `H_SYNC, `H_TOTAL, "hsync_timing");
    if (!aborted) test_sync(1'b1, `V_SYNC * `H_TOTAL, `V_TOTAL * `H_TOTAL, "vsync_timing");
    if (!aborted) test_line_buffer();
    if (!aborted) test_blanking();
    if (!aborted) test_hold_audio();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !aborted) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* tia_vga_bridge.f */
+incdir+hdl
hdl/video_pkg.sv
hdl/vga_timing.sv
hdl/line_writer.sv
hdl/scanline_buffer.sv
hdl/ntsc_palette.sv
hdl/vga_scan_out.sv
hdl/audio_pwm.sv
hdl/tia_vga_bridge.sv
verif/tia_vga_bridge_tb.sv
